// File: arm_core_tb.sv
// Programs keep three NOPs between dependent instructions; r0 is never written and stays zero
module arm_core_tb;
   import arm_pkg::*;

   localparam int clk_period = 100;
   localparam int drive_dly  = 10;
   localparam int max_wait   = 200;
   // Rough cycle budget per test, plus margin
   localparam int budget_cycles = 20 + 20 + 40 + 320 + 160 + 200 + 300;

   logic              clock;
   logic              reset;
   logic              cpu_run_i;
   logic              host_req_i;
   logic              host_sel_i;
   logic              host_we_i;
   logic [8:0]        host_addr_i;
   logic [63:0]       host_wdata_i;
   logic              host_busy_o;
   logic              host_done_o;
   logic [63:0]       host_rdata_o;

   logic              check_rd;
   logic [63:0]       exp_rdata;
   logic [31:0]       lfsr_q;
   logic [63:0]       model_regs [16];
   logic [63:0]       model_mem [256];
   logic [31:0]       prog [$];
   logic [7:0]        st_addrs [$];
   int                err_count;
   int                err_mark;
   int                tests_passed;
   int                tests_failed;
   int                lat;

   tb_clock_gen clk_gen_i (
      .clock_o (clock),
      .reset_o (reset)
   );

   arm_core_top dut_i (
      .clock        (clock),
      .reset        (reset),
      .cpu_run_i    (cpu_run_i),
      .host_req_i   (host_req_i),
      .host_sel_i   (host_sel_i),
      .host_we_i    (host_we_i),
      .host_addr_i  (host_addr_i),
      .host_wdata_i (host_wdata_i),
      .host_busy_o  (host_busy_o),
      .host_done_o  (host_done_o),
      .host_rdata_o (host_rdata_o)
   );

   // Read data in the done cycle
   assert property (@(posedge clock) disable iff (reset)
      host_done_o && check_rd |-> host_rdata_o == exp_rdata)
      else
      begin
         $display("Error host_rdata_o: got %h expected %h", $sampled(host_rdata_o), exp_rdata);
         err_count++;
      end

   // Read data still held in the cycle after done
   assert property (@(posedge clock) disable iff (reset)
      host_done_o && check_rd |=> host_rdata_o == exp_rdata)
      else
      begin
         $display("Error host_rdata_o: held %h expected %h", $sampled(host_rdata_o), exp_rdata);
         err_count++;
      end

   // Fixed latency while the pipeline is idle
   assert property (@(posedge clock) disable iff (reset)
      host_req_i && !host_busy_o && !cpu_run_i |=> !host_done_o ##1 host_done_o)
      else
      begin
         $display("Host done did not follow its request by exactly 2 cycles");
         err_count++;
      end

   assert property (@(posedge clock) disable iff (reset)
      host_busy_o && !host_done_o |=> host_busy_o)
      else
      begin
         $display("Host busy dropped before the done pulse");
         err_count++;
      end

   assert property (@(posedge clock) $fell(reset) |-> !host_busy_o && !host_done_o)
      else
      begin
         $display("Host busy or done was high straight after reset");
         err_count++;
      end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
   endfunction

   // One LFSR step per bit
   function automatic logic [63:0] rand_word();
      logic [63:0] w;
      w = '0;
      for (int k = 0; k < 64; k++)
      begin
         lfsr_q = lfsr_step(lfsr_q);
         w = {w[62:0], lfsr_q[0]};
      end
      return w;
   endfunction

   function automatic logic [31:0] encode(input logic [7:0] op, input logic [3:0] rd,
                                          input logic [3:0] rn, input logic [11:0] arg);
      instr_u w;
      w = '0;
      w.i.opcode = op;
      w.i.rn = rn;
      w.i.rd = rd;
      if (op == op_addi || op == op_ldr || op == op_str)
         w.i.imm = arg;
      else
         w.r.rm = arg[3:0];
      return w;
   endfunction

   // Appends an instruction plus gap NOPs and applies it to the model
   task automatic emit(input logic [7:0] op, input logic [3:0] rd, input logic [3:0] rn,
                       input logic [11:0] arg, input int gap);
      logic [63:0] a;
      logic [63:0] b;
      logic [63:0] ea;
      a  = model_regs[rn];
      b  = model_regs[arg[3:0]];
      ea = a + {{52{arg[11]}}, arg};
      case (op)
         op_add:  model_regs[rd] = a + b;
         op_sub:  model_regs[rd] = a - b;
         op_and:  model_regs[rd] = a & b;
         op_orr:  model_regs[rd] = a | b;
         op_addi: model_regs[rd] = ea;
         op_ldr:  model_regs[rd] = model_mem[ea[7:0]];
         op_str:
         begin
            model_mem[ea[7:0]] = model_regs[rd];
            st_addrs.push_back(ea[7:0]);
         end
         default: ;
      endcase
      prog.push_back(encode(op, rd, rn, arg));
      repeat (gap) prog.push_back(encode(op_nop, 4'h0, 4'h0, 12'h0));
   endtask

   task automatic tick(input int n);
      repeat (n)
      begin
         @(posedge clock);
         #drive_dly;
      end
   endtask

   // Starts right after an edge; returns two cycles past the done pulse
   task automatic host_cmd(input logic sel, input logic we, input logic [8:0] addr,
                           input logic [63:0] wdata, output int cycles);
      host_req_i   = 1'b1;
      host_sel_i   = sel;
      host_we_i    = we;
      host_addr_i  = addr;
      host_wdata_i = wdata;
      tick(1);
      host_req_i = 1'b0;
      cycles = 1;
      while (!host_done_o && cycles < max_wait)
      begin
         tick(1);
         cycles++;
      end
      if (!host_done_o)
      begin
         $display("Host command to address %h never finished", addr);
         err_count++;
      end
      tick(2);
      check_rd = 1'b0;
   endtask

   task automatic host_write(input logic sel, input logic [8:0] addr, input logic [63:0] data);
      int cycles;
      host_cmd(sel, 1'b1, addr, data, cycles);
      if (sel)
         model_mem[addr[7:0]] = data;
   endtask

   task automatic host_read(input logic sel, input logic [8:0] addr, input logic [63:0] expected,
                            output int cycles);
      exp_rdata = expected;
      check_rd  = 1'b1;
      host_cmd(sel, 1'b0, addr, 64'h0, cycles);
   endtask

   // Four NOPs of tail keep the fetch past the program harmless
   task automatic load_program();
      repeat (4) prog.push_back(encode(op_nop, 4'h0, 4'h0, 12'h0));
      for (int i = 0; i < prog.size(); i++)
         host_write(1'b0, i[8:0], {32'h0, prog[i]});
   endtask

   task automatic run_cpu(input int n);
      cpu_run_i = 1'b1;
      tick(n);
      cpu_run_i = 1'b0;
      // Drain the stages behind fetch
      tick(8);
   endtask

   task automatic read_stores();
      int cycles;
      foreach (st_addrs[k])
         host_read(1'b1, {1'b0, st_addrs[k]}, model_mem[st_addrs[k]], cycles);
      st_addrs.delete();
      prog.delete();
   endtask

   task automatic end_test(input int num, input string name);
      int errs;
      errs = err_count - err_mark;
      if (errs == 0)
         tests_passed++;
      else
         tests_failed++;
      $display("test %0d %s: %s (%0d errors)", num, name, errs == 0 ? "ok" : "bad", errs);
      err_mark = err_count;
   endtask

   initial
   begin
      #(budget_cycles * clk_period);
      $display("Timeout after %0d cycles, a host command or program hung", budget_cycles);
      $display("Result: FAILED");
      $finish;
   end

   initial
   begin
      logic [63:0] word;
      cpu_run_i    = 1'b0;
      host_req_i   = 1'b0;
      host_sel_i   = 1'b0;
      host_we_i    = 1'b0;
      host_addr_i  = '0;
      host_wdata_i = '0;
      check_rd     = 1'b0;
      exp_rdata    = '0;
      lfsr_q       = 32'd99221;
      err_count    = 0;
      err_mark     = 0;
      tests_passed = 0;
      tests_failed = 0;
      for (int k = 0; k < 16; k++)
         model_regs[k] = '0;

      @(negedge reset);
      tick(1);
      assert (!host_busy_o && !host_done_o)
      else
      begin
         $display("Host port not idle after reset");
         err_count++;
      end
      end_test(1, "reset state");

      // Upper half of the host word is dropped
      word = rand_word();
      host_write(1'b0, 9'h1A5, word);
      host_read(1'b0, 9'h1A5, {32'h0, word[31:0]}, lat);
      end_test(2, "imem round trip");

      for (int k = 0; k < 4; k++)
      begin
         word = rand_word();
         host_write(1'b1, {1'b0, 8'h5A * k[7:0] + 8'h0F}, word);
      end
      for (int k = 0; k < 4; k++)
         host_read(1'b1, {1'b0, 8'h5A * k[7:0] + 8'h0F}, model_mem[8'h5A * k[7:0] + 8'h0F], lat);
      end_test(3, "dmem round trip");

      emit(op_addi, 4'd1, 4'd0, 12'h123, 3);
      emit(op_addi, 4'd2, 4'd0, 12'hFBB, 3);
      emit(op_add, 4'd3, 4'd1, 12'd2, 3);
      emit(op_sub, 4'd4, 4'd1, 12'd2, 3);
      emit(op_and, 4'd5, 4'd1, 12'd2, 3);
      emit(op_orr, 4'd6, 4'd1, 12'd2, 3);
      for (int k = 1; k <= 6; k++)
         emit(op_str, k[3:0], 4'd0, 12'h010 + k[11:0], 3);
      load_program();
      run_cpu(prog.size());
      read_stores();
      end_test(4, "alu program");

      host_write(1'b1, 9'h030, rand_word());
      host_write(1'b1, 9'h031, rand_word());
      emit(op_ldr, 4'd7, 4'd0, 12'h030, 3);
      emit(op_ldr, 4'd8, 4'd0, 12'h031, 3);
      emit(op_add, 4'd9, 4'd7, 12'd8, 3);
      emit(op_str, 4'd9, 4'd0, 12'h032, 3);
      load_program();
      run_cpu(prog.size());
      read_stores();
      end_test(5, "load add store");

      // Back-to-back stores keep the data port busy
      host_write(1'b1, 9'h090, rand_word());
      for (int k = 0; k < 16; k++)
         emit(op_str, 4'd3, 4'd0, 12'h050, 0);
      load_program();
      fork
         run_cpu(prog.size());
         begin
            tick(3);
            host_read(1'b1, 9'h090, model_mem[8'h90], lat);
         end
      join
      assert (lat > 2)
      else
      begin
         $display("Host read finished in %0d cycles without waiting for the stores", lat);
         err_count++;
      end
      st_addrs.delete();
      st_addrs.push_back(8'h50);
      read_stores();
      end_test(6, "host under store traffic");

      $display("Summary: %0d tests passed, %0d tests failed, %0d failed checks",
               tests_passed, tests_failed, err_count);
      if (err_count == 0 && tests_failed == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

endmodule

// File: arm_core_top.sv
// Five-stage core; host loads memories with cpu_run_i low, no forwarding or hazard stalls
module arm_core_top
(
   input  logic                            clock,
   input  logic                            reset,
   input  logic                            cpu_run_i,
   input  logic                            host_req_i,
   input  logic                            host_sel_i,
   input  logic                            host_we_i,
   input  logic [arm_pkg::imem_addr_w-1:0] host_addr_i,
   input  logic [arm_pkg::data_w-1:0]      host_wdata_i,
   output logic                            host_busy_o,
   output logic                            host_done_o,
   output logic [arm_pkg::data_w-1:0]      host_rdata_o
);
   import arm_pkg::*;

   logic                   fetch_req;
   logic                   fetch_grant;
   logic [imem_addr_w-1:0] fetch_addr;
   logic [instr_w-1:0]     fetch_instr;
   logic                   ifid_valid;
   instr_u                 ifid_instr;
   logic [data_w-1:0]      idex_a;
   logic [data_w-1:0]      idex_b;
   logic [data_w-1:0]      idex_imm;
   logic [1:0]             idex_alu_op;
   logic                   idex_use_imm;
   logic                   idex_mem_rd;
   logic                   idex_mem_wr;
   logic                   idex_reg_we;
   logic [reg_addr_w-1:0]  idex_rd;
   logic                   mem_rd;
   logic                   mem_wr;
   logic [dmem_addr_w-1:0] mem_addr;
   logic [data_w-1:0]      mem_wdata;
   logic [data_w-1:0]      mem_rdata;
   logic [data_w-1:0]      exmem_alu;
   logic                   exmem_reg_we;
   logic                   exmem_mem2reg;
   logic [reg_addr_w-1:0]  exmem_rd;
   logic                   wb_we;
   logic [reg_addr_w-1:0]  wb_rd;
   logic [data_w-1:0]      wb_data;

   instr_fetch fetch_i (
      .clock         (clock),
      .reset         (reset),
      .cpu_run_i     (cpu_run_i),
      .fetch_grant_i (fetch_grant),
      .fetch_instr_i (fetch_instr),
      .fetch_req_o   (fetch_req),
      .fetch_addr_o  (fetch_addr),
      .ifid_valid_o  (ifid_valid),
      .ifid_instr_o  (ifid_instr)
   );

   decode_stage decode_i (
      .clock          (clock),
      .reset          (reset),
      .ifid_valid_i   (ifid_valid),
      .ifid_instr_i   (ifid_instr),
      .wb_we_i        (wb_we),
      .wb_rd_i        (wb_rd),
      .wb_data_i      (wb_data),
      .idex_a_o       (idex_a),
      .idex_b_o       (idex_b),
      .idex_imm_o     (idex_imm),
      .idex_alu_op_o  (idex_alu_op),
      .idex_use_imm_o (idex_use_imm),
      .idex_mem_rd_o  (idex_mem_rd),
      .idex_mem_wr_o  (idex_mem_wr),
      .idex_reg_we_o  (idex_reg_we),
      .idex_rd_o      (idex_rd)
   );

   execute_stage execute_i (
      .clock           (clock),
      .reset           (reset),
      .idex_a_i        (idex_a),
      .idex_b_i        (idex_b),
      .idex_imm_i      (idex_imm),
      .idex_alu_op_i   (idex_alu_op),
      .idex_use_imm_i  (idex_use_imm),
      .idex_mem_rd_i   (idex_mem_rd),
      .idex_mem_wr_i   (idex_mem_wr),
      .idex_reg_we_i   (idex_reg_we),
      .idex_rd_i       (idex_rd),
      .mem_rd_o        (mem_rd),
      .mem_wr_o        (mem_wr),
      .mem_addr_o      (mem_addr),
      .mem_wdata_o     (mem_wdata),
      .exmem_alu_o     (exmem_alu),
      .exmem_reg_we_o  (exmem_reg_we),
      .exmem_mem2reg_o (exmem_mem2reg),
      .exmem_rd_o      (exmem_rd)
   );

   mem_arbiter arbiter_i (
      .clock         (clock),
      .reset         (reset),
      .fetch_req_i   (fetch_req),
      .fetch_addr_i  (fetch_addr),
      .fetch_grant_o (fetch_grant),
      .fetch_instr_o (fetch_instr),
      .mem_rd_i      (mem_rd),
      .mem_wr_i      (mem_wr),
      .mem_addr_i    (mem_addr),
      .mem_wdata_i   (mem_wdata),
      .mem_rdata_o   (mem_rdata),
      .host_req_i    (host_req_i),
      .host_sel_i    (host_sel_i),
      .host_we_i     (host_we_i),
      .host_addr_i   (host_addr_i),
      .host_wdata_i  (host_wdata_i),
      .host_busy_o   (host_busy_o),
      .host_done_o   (host_done_o),
      .host_rdata_o  (host_rdata_o)
   );

   writeback_stage writeback_i (
      .clock           (clock),
      .reset           (reset),
      .exmem_alu_i     (exmem_alu),
      .exmem_reg_we_i  (exmem_reg_we),
      .exmem_mem2reg_i (exmem_mem2reg),
      .exmem_rd_i      (exmem_rd),
      .mem_rdata_i     (mem_rdata),
      .wb_we_o         (wb_we),
      .wb_rd_o         (wb_rd),
      .wb_data_o       (wb_data)
   );

endmodule

// File: arm_pkg.sv
// Shared constants and instruction format; unknown opcodes execute as NOP, no branch encodings
package arm_pkg;

   // Datapath and memory geometry
   localparam int data_w      = 64;
   localparam int instr_w     = 32;
   localparam int reg_addr_w  = 4;
   localparam int num_regs    = 16;
   localparam int imem_depth  = 512;
   localparam int imem_addr_w = 9;
   localparam int dmem_depth  = 256;
   localparam int dmem_addr_w = 8;
   localparam int opcode_w    = 8;
   localparam int imm_w       = 12;

   // Opcode field values
   localparam logic [opcode_w-1:0] op_nop  = 8'h00;
   localparam logic [opcode_w-1:0] op_add  = 8'h01;
   localparam logic [opcode_w-1:0] op_sub  = 8'h02;
   localparam logic [opcode_w-1:0] op_and  = 8'h03;
   localparam logic [opcode_w-1:0] op_orr  = 8'h04;
   localparam logic [opcode_w-1:0] op_addi = 8'h05;
   localparam logic [opcode_w-1:0] op_ldr  = 8'h06;
   localparam logic [opcode_w-1:0] op_str  = 8'h07;

   // ALU operations, decode to execute
   localparam logic [1:0] alu_add = 2'd0;
   localparam logic [1:0] alu_sub = 2'd1;
   localparam logic [1:0] alu_and = 2'd2;
   localparam logic [1:0] alu_orr = 2'd3;

   // One instruction word, seen as register form or immediate form
   typedef union packed {
      struct packed {
         logic [3:0]            unused_hi;
         logic [opcode_w-1:0]   opcode;
         logic [reg_addr_w-1:0] rn;
         logic [reg_addr_w-1:0] rd;
         logic [7:0]            unused_lo;
         logic [reg_addr_w-1:0] rm;
      } r;
      struct packed {
         logic [3:0]            unused_hi;
         logic [opcode_w-1:0]   opcode;
         logic [reg_addr_w-1:0] rn;
         logic [reg_addr_w-1:0] rd;
         logic [imm_w-1:0]      imm;
      } i;
   } instr_u;

endpackage

// File: decode_stage.sv
// No hazard detection; a consumer must trail its producer by three slots, write-first regfile
module decode_stage
(
   input  logic                           clock,
   input  logic                           reset,
   input  logic                           ifid_valid_i,
   input  arm_pkg::instr_u                ifid_instr_i,
   input  logic                           wb_we_i,
   input  logic [arm_pkg::reg_addr_w-1:0] wb_rd_i,
   input  logic [arm_pkg::data_w-1:0]     wb_data_i,
   output logic [arm_pkg::data_w-1:0]     idex_a_o,
   output logic [arm_pkg::data_w-1:0]     idex_b_o,
   output logic [arm_pkg::data_w-1:0]     idex_imm_o,
   output logic [1:0]                     idex_alu_op_o,
   output logic                           idex_use_imm_o,
   output logic                           idex_mem_rd_o,
   output logic                           idex_mem_wr_o,
   output logic                           idex_reg_we_o,
   output logic [arm_pkg::reg_addr_w-1:0] idex_rd_o
);
   import arm_pkg::*;

   logic [data_w-1:0]     regs [num_regs];
   logic [1:0]            alu_op;
   logic                  use_imm;
   logic                  mem_rd;
   logic                  mem_wr;
   logic                  reg_we;
   logic                  b_from_rd;
   logic [reg_addr_w-1:0] rb_addr;
   logic [data_w-1:0]     rd_a;
   logic [data_w-1:0]     rd_b;
   logic [data_w-1:0]     imm_ext;

   // Control decode
   always_comb
   begin
      alu_op    = alu_add;
      use_imm   = 1'b0;
      mem_rd    = 1'b0;
      mem_wr    = 1'b0;
      reg_we    = 1'b0;
      b_from_rd = 1'b0;
      case (ifid_instr_i.r.opcode)
         op_add:  reg_we = 1'b1;
         op_sub:
         begin
            alu_op = alu_sub;
            reg_we = 1'b1;
         end
         op_and:
         begin
            alu_op = alu_and;
            reg_we = 1'b1;
         end
         op_orr:
         begin
            alu_op = alu_orr;
            reg_we = 1'b1;
         end
         op_addi:
         begin
            use_imm = 1'b1;
            reg_we  = 1'b1;
         end
         op_ldr:
         begin
            use_imm = 1'b1;
            mem_rd  = 1'b1;
            reg_we  = 1'b1;
         end
         op_str:
         begin
            // Store data comes from rd
            use_imm   = 1'b1;
            mem_wr    = 1'b1;
            b_from_rd = 1'b1;
         end
         // NOP and unknown opcodes
         default: reg_we = 1'b0;
      endcase
   end

   assign rb_addr = b_from_rd ? ifid_instr_i.r.rd : ifid_instr_i.r.rm;
   assign imm_ext = {{(data_w-imm_w){ifid_instr_i.i.imm[imm_w-1]}}, ifid_instr_i.i.imm};

   // Write-first reads
   assign rd_a = (wb_we_i && wb_rd_i == ifid_instr_i.r.rn) ? wb_data_i
                                                           : regs[ifid_instr_i.r.rn];
   assign rd_b = (wb_we_i && wb_rd_i == rb_addr) ? wb_data_i : regs[rb_addr];

   // Registers start at zero so programs can build constants with ADDI
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         for (int k = 0; k < num_regs; k++)
         begin
            regs[k] <= '0;
         end
      end
      else if (wb_we_i)
      begin
         regs[wb_rd_i] <= wb_data_i;
      end
   end

   // ID/EX register
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         idex_mem_rd_o <= 1'b0;
         idex_mem_wr_o <= 1'b0;
         idex_reg_we_o <= 1'b0;
      end
      else
      begin
         idex_mem_rd_o <= mem_rd && ifid_valid_i;
         idex_mem_wr_o <= mem_wr && ifid_valid_i;
         idex_reg_we_o <= reg_we && ifid_valid_i;
      end
      idex_a_o       <= rd_a;
      idex_b_o       <= rd_b;
      idex_imm_o     <= imm_ext;
      idex_alu_op_o  <= alu_op;
      idex_use_imm_o <= use_imm;
      idex_rd_o      <= ifid_instr_i.r.rd;
   end

endmodule

// File: execute_stage.sv
// 64-bit ALU without flags; the data address is the low byte of the ALU result
module execute_stage
(
   input  logic                            clock,
   input  logic                            reset,
   input  logic [arm_pkg::data_w-1:0]      idex_a_i,
   input  logic [arm_pkg::data_w-1:0]      idex_b_i,
   input  logic [arm_pkg::data_w-1:0]      idex_imm_i,
   input  logic [1:0]                      idex_alu_op_i,
   input  logic                            idex_use_imm_i,
   input  logic                            idex_mem_rd_i,
   input  logic                            idex_mem_wr_i,
   input  logic                            idex_reg_we_i,
   input  logic [arm_pkg::reg_addr_w-1:0]  idex_rd_i,
   output logic                            mem_rd_o,
   output logic                            mem_wr_o,
   output logic [arm_pkg::dmem_addr_w-1:0] mem_addr_o,
   output logic [arm_pkg::data_w-1:0]      mem_wdata_o,
   output logic [arm_pkg::data_w-1:0]      exmem_alu_o,
   output logic                            exmem_reg_we_o,
   output logic                            exmem_mem2reg_o,
   output logic [arm_pkg::reg_addr_w-1:0]  exmem_rd_o
);
   import arm_pkg::*;

   logic [data_w-1:0] op_b;
   logic [data_w-1:0] alu_res;

   assign op_b = idex_use_imm_i ? idex_imm_i : idex_b_i;

   always_comb
   begin
      case (idex_alu_op_i)
         alu_sub: alu_res = idex_a_i - op_b;
         alu_and: alu_res = idex_a_i & op_b;
         alu_orr: alu_res = idex_a_i | op_b;
         default: alu_res = idex_a_i + op_b;
      endcase
   end

   // EX/MEM register
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         mem_rd_o        <= 1'b0;
         mem_wr_o        <= 1'b0;
         exmem_reg_we_o  <= 1'b0;
         exmem_mem2reg_o <= 1'b0;
      end
      else
      begin
         mem_rd_o        <= idex_mem_rd_i;
         mem_wr_o        <= idex_mem_wr_i;
         exmem_reg_we_o  <= idex_reg_we_i;
         // Only loads return memory data to the register file
         exmem_mem2reg_o <= idex_mem_rd_i;
      end
      exmem_alu_o <= alu_res;
      mem_wdata_o <= idex_b_i;
      exmem_rd_o  <= idex_rd_i;
   end

   assign mem_addr_o = exmem_alu_o[dmem_addr_w-1:0];

   // Decode never marks an instruction as both load and store
   assert property (@(posedge clock) disable iff (reset) !(mem_rd_o && mem_wr_o))
      else $error("Load and store issued together");

endmodule

// File: instr_fetch.sv
// PC counts words from zero; no branches, and fetch idles at PC 0 while cpu_run_i is low
module instr_fetch
(
   input  logic                          clock,
   input  logic                          reset,
   input  logic                          cpu_run_i,
   input  logic                          fetch_grant_i,
   input  logic [arm_pkg::instr_w-1:0]   fetch_instr_i,
   output logic                          fetch_req_o,
   output logic [arm_pkg::imem_addr_w-1:0] fetch_addr_o,
   output logic                          ifid_valid_o,
   output arm_pkg::instr_u               ifid_instr_o
);
   import arm_pkg::*;

   logic [imem_addr_w-1:0] pc_q;
   logic                   valid_q;

   assign fetch_req_o  = cpu_run_i;
   assign fetch_addr_o = pc_q;

   always_ff @(posedge clock)
   begin
      if (reset || !cpu_run_i)
      begin
         pc_q    <= '0;
         valid_q <= 1'b0;
      end
      else
      begin
         // Instruction returns next cycle from the synchronous read
         valid_q <= fetch_grant_i;
         if (fetch_grant_i)
         begin
            pc_q <= pc_q + 1'b1;
         end
      end
   end

   assign ifid_valid_o = valid_q;

   // Bubble when the slot carries no fetched word
   assign ifid_instr_o = valid_q ? fetch_instr_i : {4'h0, op_nop, 20'h0};

   // A denied fetch must replay the same address
   assert property (@(posedge clock) disable iff (reset)
      cpu_run_i && !fetch_grant_i |=> pc_q == $past(pc_q))
      else $error("PC moved without a fetch grant");

endmodule

// File: mem_arbiter.sv
// Single-port memories; host wins imem, pipeline wins dmem, one host command in flight
module mem_arbiter
(
   input  logic                            clock,
   input  logic                            reset,
   input  logic                            fetch_req_i,
   input  logic [arm_pkg::imem_addr_w-1:0] fetch_addr_i,
   output logic                            fetch_grant_o,
   output logic [arm_pkg::instr_w-1:0]     fetch_instr_o,
   input  logic                            mem_rd_i,
   input  logic                            mem_wr_i,
   input  logic [arm_pkg::dmem_addr_w-1:0] mem_addr_i,
   input  logic [arm_pkg::data_w-1:0]      mem_wdata_i,
   output logic [arm_pkg::data_w-1:0]      mem_rdata_o,
   input  logic                            host_req_i,
   input  logic                            host_sel_i,
   input  logic                            host_we_i,
   input  logic [arm_pkg::imem_addr_w-1:0] host_addr_i,
   input  logic [arm_pkg::data_w-1:0]      host_wdata_i,
   output logic                            host_busy_o,
   output logic                            host_done_o,
   output logic [arm_pkg::data_w-1:0]      host_rdata_o
);
   import arm_pkg::*;

   logic [instr_w-1:0]     imem [imem_depth];
   logic [data_w-1:0]      dmem [dmem_depth];
   logic [instr_w-1:0]     imem_rd_q;
   logic [data_w-1:0]      dmem_rd_q;
   logic                   pend_q;
   logic                   done_q;
   logic                   cmd_sel_q;
   logic                   cmd_we_q;
   logic [imem_addr_w-1:0] cmd_addr_q;
   logic [data_w-1:0]      cmd_wdata_q;
   logic [data_w-1:0]      hold_q;
   logic                   host_active;
   logic                   host_imem_go;
   logic                   host_dmem_go;
   logic                   pipe_dmem;
   logic [imem_addr_w-1:0] imem_addr;
   logic [dmem_addr_w-1:0] dmem_addr;
   logic                   dmem_we;
   logic [data_w-1:0]      dmem_wdata;
   logic [data_w-1:0]      host_live;

   // Host command register
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         pend_q <= 1'b0;
         done_q <= 1'b0;
      end
      else
      begin
         done_q <= host_imem_go || host_dmem_go;
         if (done_q)
         begin
            pend_q <= 1'b0;
         end
         else if (host_req_i && !pend_q)
         begin
            pend_q <= 1'b1;
         end
      end
      if (host_req_i && !pend_q)
      begin
         cmd_sel_q   <= host_sel_i;
         cmd_we_q    <= host_we_i;
         cmd_addr_q  <= host_addr_i;
         cmd_wdata_q <= host_wdata_i;
      end
   end

   // Command still waits for its memory slot
   assign host_active  = pend_q && !done_q;
   assign pipe_dmem    = mem_rd_i || mem_wr_i;
   assign host_imem_go = host_active && !cmd_sel_q;
   assign host_dmem_go = host_active && cmd_sel_q && !pipe_dmem;

   assign fetch_grant_o = fetch_req_i && !host_imem_go;

   // Instruction memory port
   assign imem_addr = host_imem_go ? cmd_addr_q : fetch_addr_i;

   always_ff @(posedge clock)
   begin
      if (host_imem_go && cmd_we_q)
      begin
         imem[imem_addr] <= cmd_wdata_q[instr_w-1:0];
      end
      imem_rd_q <= imem[imem_addr];
   end

   assign fetch_instr_o = imem_rd_q;

   // Data memory port
   assign dmem_addr  = host_dmem_go ? cmd_addr_q[dmem_addr_w-1:0] : mem_addr_i;
   assign dmem_we    = host_dmem_go ? cmd_we_q : mem_wr_i;
   assign dmem_wdata = host_dmem_go ? cmd_wdata_q : mem_wdata_i;

   always_ff @(posedge clock)
   begin
      if (dmem_we)
      begin
         dmem[dmem_addr] <= dmem_wdata;
      end
      dmem_rd_q <= dmem[dmem_addr];
   end

   assign mem_rdata_o = dmem_rd_q;

   // Host read data shows in the done cycle and is held afterwards
   assign host_live = cmd_sel_q ? dmem_rd_q : {{(data_w-instr_w){1'b0}}, imem_rd_q};

   always_ff @(posedge clock)
   begin
      if (done_q)
      begin
         hold_q <= host_live;
      end
   end

   assign host_rdata_o = done_q ? host_live : hold_q;
   assign host_busy_o  = pend_q;
   assign host_done_o  = done_q;

   assert property (@(posedge clock) disable iff (reset)
      host_done_o |-> host_busy_o && $past(host_busy_o))
      else $error("Host done without a pending command");

   // A finished data command had the array to itself
   assert property (@(posedge clock) disable iff (reset)
      host_done_o && cmd_sel_q |-> $past(!(mem_rd_i || mem_wr_i)))
      else $error("Host and pipeline shared the data array");

endmodule

// File: sources.f
arm_pkg.sv
instr_fetch.sv
decode_stage.sv
execute_stage.sv
mem_arbiter.sv
writeback_stage.sv
arm_core_top.sv
tb_clock_gen.sv
arm_core_tb.sv

// File: tb_clock_gen.sv
// Free-running clock of period 100 from time 0; reset high until just after the third rising edge
module tb_clock_gen
(
   output logic clock_o,
   output logic reset_o
);
   localparam int half_period = 50;

   initial
   begin
      clock_o = 1'b0;
      forever #half_period clock_o = ~clock_o;
   end

   initial
   begin
      reset_o = 1'b1;
      repeat (3) @(posedge clock_o);
      #10 reset_o = 1'b0;
   end

endmodule

// File: writeback_stage.sv
// Load data arrives unregistered from the data array in the writeback cycle
module writeback_stage
(
   input  logic                           clock,
   input  logic                           reset,
   input  logic [arm_pkg::data_w-1:0]     exmem_alu_i,
   input  logic                           exmem_reg_we_i,
   input  logic                           exmem_mem2reg_i,
   input  logic [arm_pkg::reg_addr_w-1:0] exmem_rd_i,
   input  logic [arm_pkg::data_w-1:0]     mem_rdata_i,
   output logic                           wb_we_o,
   output logic [arm_pkg::reg_addr_w-1:0] wb_rd_o,
   output logic [arm_pkg::data_w-1:0]     wb_data_o
);
   import arm_pkg::*;

   logic [data_w-1:0] alu_q;
   logic              mem2reg_q;

   // MEM/WB register
   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wb_we_o   <= 1'b0;
         mem2reg_q <= 1'b0;
      end
      else
      begin
         wb_we_o   <= exmem_reg_we_i;
         mem2reg_q <= exmem_mem2reg_i;
      end
      alu_q   <= exmem_alu_i;
      wb_rd_o <= exmem_rd_i;
   end

   assign wb_data_o = mem2reg_q ? mem_rdata_i : alu_q;

endmodule
